/* list.f */
+incdir+source
source/sched_pkg.sv
source/sched_sequencer.sv
source/x_tile_iter.sv
source/w_tile_iter.sv
source/z_drain_iter.sv
source/matmul_scheduler.sv
verification/tb_matmul_scheduler.sv

/* verification/tb_matmul_scheduler.sv */
// Matrix-multiply scheduler testbench

`include "sched_consts.svh"

module tb_matmul_scheduler
  import sched_pkg::*;
();

  logic       clk_i = 1'b0;
  logic       rst_ni, clear_i, start_i, x_valid_i, w_valid_i;
  tile_cfg_t  cfg_i;
  buf_flags_t flags_i;
  x_ctrl_t    x_ctrl_o;
  w_ctrl_t    w_ctrl_o;
  z_ctrl_t    z_ctrl_o;
  logic       reg_enable_o, w_loaded_o;

  logic [31:0] lfsr = 32'h9da4_f6b8;
  string       test_name = "reset";
  logic        start_req = 1'b0, clear_req = 1'b0, random_w = 1'b0, load_seen = 1'b0;
  logic        started = 1'b0, gap_valid = 1'b0, xfull_held = 1'b0, x_seen = 1'b0;
  logic        z_seen = 1'b0;
  int          z_hold = 0, fill_wait = 0, empties_sent = 0, shift_total = 0, gap = 0;
  int          exp_loads = 0, load_cnt = 0, zero_rows = 0, h_cnt = 0, wl_cnt = 0, last_cnt = 0;
  int          value_errs = 0, rule_errs = 0, cycles = 0, cycle_limit = 0;

  matmul_scheduler dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic lfsr_step();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'hD000_0001;
    end
    return b;
  endfunction

  function automatic tile_cfg_t make_cfg(int xc, int xr, int wc, int wr, logic y);
    tile_cfg_t c;
    c.x_cols_iters = iter_cnt_t'(xc);
    c.x_rows_iters = iter_cnt_t'(xr);
    c.w_cols_iters = iter_cnt_t'(wc);
    c.w_rows_iters = iter_cnt_t'(wr);
    c.y_needed     = y;
    return c;
  endfunction

  // Three cycles per weight row plus headroom for preload and drain
  function automatic int run_budget(tile_cfg_t c);
    return int'(c.w_rows_iters) * int'(c.w_cols_iters) * int'(c.x_rows_iters) * 3 + 50;
  endfunction

  task automatic log_mismatch(string check, int expected, int actual);
    value_errs++;
    $display("** Error [%s/%s] expected %0d, actual %0d", test_name, check, expected, actual);
  endtask

  task automatic log_violation(string msg);
    rule_errs++;
    $display("** Error [%s] %s", test_name, msg);
  endtask

  // Drives one cycle of inputs on the falling edge, emulating the operand buffers
  task automatic drive_cycle();
    logic b0, b1;
    @(negedge clk_i);
    start_i = start_req;
    clear_i = clear_req;
    flags_i.x_empty = 1'b0;
    flags_i.z_empty = 1'b0;
    if (clear_req) begin
      flags_i.x_full = 1'b0;
      fill_wait = 0;
      empties_sent = 0;
    end else if (shift_total / `SCHED_ARRAY_H > empties_sent) begin
      // The array has consumed the whole X tile
      flags_i.x_empty = 1'b1;
      flags_i.x_full = 1'b0;
      fill_wait = 0;
      empties_sent++;
    end else if (fill_wait > 0) begin
      fill_wait--;
      if (fill_wait == 0) begin
        flags_i.x_full = 1'b1;
      end
    end else if (load_seen && !flags_i.x_full) begin
      fill_wait = 3;
    end
    if (z_hold > 0) begin
      z_hold--;
      flags_i.z_loaded = 1'b0;
    end else begin
      flags_i.z_loaded = 1'b1;
    end
    if (random_w) begin
      b0 = lfsr_step();
      b1 = lfsr_step();
      w_valid_i = b0 | b1;
    end else begin
      w_valid_i = 1'b1;
    end
  endtask

  // Samples every cycle once inputs and outputs have settled
  always @(negedge clk_i) begin
    #1;
    if (rst_ni) begin
      if (!started) begin
        assert ({x_ctrl_o, w_ctrl_o, z_ctrl_o, reg_enable_o} == '0)
          else log_mismatch("idle_outputs", 0, int'({x_ctrl_o, w_ctrl_o, z_ctrl_o, reg_enable_o}));
      end
      if (start_i) begin
        started   = 1'b1;
        gap_valid = 1'b0;
        x_seen    = 1'b0;
        z_seen    = 1'b0;
      end
      x_seen = x_seen || flags_i.x_full;
      z_seen = z_seen || flags_i.z_loaded;
      if (w_loaded_o) begin
        assert (cfg_i.y_needed ? z_seen : x_seen)
          else log_violation("weights were loaded before the operand buffers were ready");
      end
      assert (!((w_loaded_o || w_ctrl_o.load) && !w_valid_i && load_cnt < exp_loads))
        else log_violation("weights were loaded while w_valid_i was low");
      assert (w_ctrl_o.zero_set == row_mask_t'((1 << zero_rows) - 1))
        else log_mismatch("zero_fill", (1 << zero_rows) - 1, int'(w_ctrl_o.zero_set));
      // Spacing is only defined while no source of stall is active
      xfull_held = xfull_held && flags_i.x_full;
      if (w_loaded_o) begin
        if (gap_valid && !random_w && xfull_held) begin
          assert (gap == `SCHED_PIPE_REGS + 1)
            else log_mismatch("load_spacing", `SCHED_PIPE_REGS + 1, gap);
        end
        gap        = 1;
        gap_valid  = 1'b1;
        xfull_held = 1'b1;
      end else begin
        gap++;
      end
      if (clear_i) begin
        load_cnt    = 0;
        zero_rows   = 0;
        h_cnt       = 0;
        wl_cnt      = 0;
        last_cnt    = 0;
        shift_total = 0;
      end else begin
        if (w_ctrl_o.load) begin
          load_cnt++;
        end else if (w_loaded_o && load_cnt == exp_loads && zero_rows < `SCHED_ARRAY_H) begin
          zero_rows++;
        end
        h_cnt       += int'(x_ctrl_o.h_shift);
        shift_total += int'(x_ctrl_o.h_shift);
        wl_cnt      += int'(w_loaded_o);
        last_cnt    += int'(x_ctrl_o.last_x);
      end
      load_seen = x_ctrl_o.load;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the runs did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic run_case(string name, tile_cfg_t cfg, logic rand_valid, int z_delay);
    int idle;
    int exp_tiles;
    int exp_last;
    test_name = name;
    cfg_i     = cfg;
    random_w  = rand_valid;
    z_hold    = z_delay;
    exp_loads = int'(cfg.w_rows_iters) * int'(cfg.w_cols_iters) * int'(cfg.x_rows_iters);
    exp_tiles = int'(cfg.x_cols_iters) * int'(cfg.w_cols_iters) * int'(cfg.x_rows_iters);
    start_req = 1'b1;
    drive_cycle();
    start_req = 1'b0;
    do begin
      drive_cycle();
    end while (!reg_enable_o);
    // A run is over once the register enable stays low
    idle = 0;
    while (idle < 16) begin
      drive_cycle();
      idle = reg_enable_o ? 0 : idle + 1;
    end
    exp_last = (empties_sent >= exp_tiles) ? 1 : 0;
    assert (load_cnt == exp_loads) else log_mismatch("w_load_count", exp_loads, load_cnt);
    assert (h_cnt == wl_cnt) else log_mismatch("h_shift_count", wl_cnt, h_cnt);
    assert (last_cnt == exp_last) else log_mismatch("last_x_count", exp_last, last_cnt);
    clear_req = 1'b1;
    drive_cycle();
    clear_req = 1'b0;
    drive_cycle();
  endtask

  initial begin
    tile_cfg_t small_cfg;
    tile_cfg_t full_cfg;
    small_cfg   = make_cfg(1, 1, 1, 1, 1'b0);
    full_cfg    = make_cfg(2, 2, 2, 2, 1'b1);
    cycle_limit = 10 * (run_budget(small_cfg) + 2 * run_budget(full_cfg));
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    cfg_i       = small_cfg;
    flags_i     = '0;
    x_valid_i   = 1'b1;
    w_valid_i   = 1'b1;
    repeat (5) drive_cycle();
    rst_ni = 1'b1;
    repeat (4) drive_cycle();
    run_case("run_one", small_cfg, 1'b0, 0);
    run_case("run_two", full_cfg, 1'b0, 0);
    run_case("run_three", full_cfg, 1'b1, 12);
    $display("Errors: %0d value mismatches, %0d rule violations", value_errs, rule_errs);
    if (value_errs + rule_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* source/matmul_scheduler.sv */
// Systolic matrix-multiply scheduler

module matmul_scheduler
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       start_i,
  input  tile_cfg_t  cfg_i,
  input  buf_flags_t flags_i,
  input  logic       x_valid_i,
  input  logic       w_valid_i,
  output x_ctrl_t    x_ctrl_o,
  output w_ctrl_t    w_ctrl_o,
  output z_ctrl_t    z_ctrl_o,
  output logic       reg_enable_o,
  output logic       w_loaded_o
);

  seq_steps_t   steps;
  iter_status_t status;
  x_ctrl_t      x_ctrl;
  logic         pad_setup;
  logic         x_done, x_refill_due;
  logic         w_done, w_col_wrap;
  logic         z_check_due, z_avail_clr;

  assign status = '{x_done: x_done, x_refill_due: x_refill_due, w_done: w_done,
                    z_check_due: z_check_due, z_avail_clr: z_avail_clr};

  sched_sequencer u_sequencer (
    .clk_i, .rst_ni, .clear_i, .start_i,
    .y_needed_i   (cfg_i.y_needed),
    .flags_i, .w_valid_i,
    .status_i     (status),
    .steps_o      (steps),
    .pad_setup_o  (pad_setup),
    .reg_enable_o, .w_loaded_o
  );

  x_tile_iter u_x_iter (
    .clk_i, .rst_ni, .clear_i, .cfg_i, .flags_i, .x_valid_i,
    .steps_i        (steps),
    .x_ctrl_o       (x_ctrl),
    .x_done_o       (x_done),
    .x_refill_due_o (x_refill_due)
  );

  w_tile_iter u_w_iter (
    .clk_i, .rst_ni, .clear_i, .cfg_i, .w_valid_i,
    .steps_i      (steps),
    .w_ctrl_o, .w_done_o (w_done), .w_col_wrap_o (w_col_wrap)
  );

  z_drain_iter u_z_iter (
    .clk_i, .rst_ni, .clear_i, .cfg_i, .flags_i,
    .steps_i       (steps),
    .w_col_wrap_i  (w_col_wrap),
    .z_ctrl_o, .z_check_due_o (z_check_due), .z_avail_clr_o (z_avail_clr)
  );

  // Pad setup is owned by the sequencer while the iterator owns the other X controls
  always_comb begin
    x_ctrl_o           = x_ctrl;
    x_ctrl_o.pad_setup = pad_setup;
  end

endmodule

/* source/z_drain_iter.sv */
// Y and Z drain iterator

`include "sched_consts.svh"

module z_drain_iter
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  tile_cfg_t  cfg_i,
  input  buf_flags_t flags_i,
  input  seq_steps_t steps_i,
  input  logic       w_col_wrap_i,
  output z_ctrl_t    z_ctrl_o,
  output logic       z_check_due_o,
  output logic       z_avail_clr_o
);

  iter_cnt_t  y_cols_q, y_rows_q;
  logic       y_cols_last, y_rows_last, y_col_step, y_row_step;
  logic       drained_all_q;
  pipe_cnt_t  wait_q;
  logic       wait_en_q, wait_last, wait_clr;
  depth_cnt_t avail_q;
  logic       avail_en_q, avail_clr, avail_done_q;
  depth_cnt_t push_q;
  logic       push_en_q, push_open, push_clr;

  assign y_cols_last = y_cols_q == cfg_i.w_cols_iters - iter_cnt_t'(1);
  assign y_rows_last = y_rows_q == cfg_i.x_rows_iters - iter_cnt_t'(1);
  assign y_col_step  = flags_i.z_empty && ~drained_all_q;
  assign y_row_step  = y_col_step && y_cols_last;

  // Results of a column leave the array PIPE_REGS steps after its last weight row
  assign wait_last = wait_q == pipe_cnt_t'(`SCHED_PIPE_REGS);
  assign wait_clr  = wait_en_q && steps_i.run && wait_last;
  assign avail_clr = avail_en_q && steps_i.run && (avail_q == depth_cnt_t'(`SCHED_DEPTH - 1));
  assign push_clr  = push_en_q && steps_i.run && (push_q == depth_cnt_t'(`SCHED_DEPTH - 1));
  // Y rows are pushed one step ahead so they meet the first results
  assign push_open = (wait_en_q && steps_i.run &&
                      wait_q == pipe_cnt_t'(`SCHED_PIPE_REGS - 1)) || steps_i.compute_start;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      y_cols_q      <= '0;
      y_rows_q      <= '0;
      drained_all_q <= 1'b0;
      wait_en_q     <= 1'b0;
      wait_q        <= '0;
      avail_en_q    <= 1'b0;
      avail_q       <= '0;
      avail_done_q  <= 1'b0;
      push_en_q     <= 1'b0;
      push_q        <= '0;
    end else if (clear_i) begin
      y_cols_q      <= '0;
      y_rows_q      <= '0;
      drained_all_q <= 1'b0;
      wait_en_q     <= 1'b0;
      wait_q        <= '0;
      avail_en_q    <= 1'b0;
      avail_q       <= '0;
      avail_done_q  <= 1'b0;
      push_en_q     <= 1'b0;
      push_q        <= '0;
    end else begin
      if (y_col_step) begin
        y_cols_q <= y_cols_last ? '0 : y_cols_q + 1'b1;
      end
      if (y_row_step) begin
        y_rows_q <= y_rows_last ? '0 : y_rows_q + 1'b1;
      end
      if (y_row_step && y_rows_last) begin
        drained_all_q <= 1'b1;
      end
      if (wait_clr) begin
        wait_en_q <= 1'b0;
      end else if (w_col_wrap_i) begin
        wait_en_q <= 1'b1;
      end
      if (wait_en_q && steps_i.run) begin
        wait_q <= wait_last ? '0 : wait_q + 1'b1;
      end
      if (avail_clr) begin
        avail_en_q <= 1'b0;
      end else if (wait_clr) begin
        avail_en_q <= 1'b1;
      end
      if (avail_en_q && steps_i.run) begin
        avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      end
      if (avail_clr) begin
        avail_done_q <= 1'b1;
      end
      if (push_clr) begin
        push_en_q <= 1'b0;
      end else if (push_open) begin
        push_en_q <= 1'b1;
      end
      if (push_en_q && steps_i.run) begin
        push_q <= push_clr ? '0 : push_q + 1'b1;
      end
    end
  end

  always_comb begin
    z_ctrl_o.y_push_enable = push_en_q && steps_i.run && cfg_i.y_needed;
    z_ctrl_o.fill          = avail_en_q && steps_i.run && ~drained_all_q;
  end

  assign z_check_due_o = wait_en_q && wait_last && steps_i.in_load_w;
  // High only once every armed column has gone through its availability window
  assign z_avail_clr_o = avail_done_q && ~wait_en_q && ~avail_en_q;

endmodule

/* source/w_tile_iter.sv */
// W operand tile iterator

`include "sched_consts.svh"

module w_tile_iter
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  tile_cfg_t  cfg_i,
  input  logic       w_valid_i,
  input  seq_steps_t steps_i,
  output w_ctrl_t    w_ctrl_o,
  output logic       w_done_o,
  output logic       w_col_wrap_o
);

  iter_cnt_t rows_q;
  iter_cnt_t cols_q;
  iter_cnt_t pass_q;
  zero_cnt_t zero_q;
  logic      rows_last, cols_last, pass_last;
  logic      row_step, col_step, pass_step;
  logic      done_q, done_set;

  assign rows_last = rows_q == cfg_i.w_rows_iters - iter_cnt_t'(1);
  assign cols_last = cols_q == cfg_i.w_cols_iters - iter_cnt_t'(1);
  assign pass_last = pass_q == cfg_i.x_rows_iters - iter_cnt_t'(1);

  // The whole W matrix is streamed once for every row of X tiles
  assign row_step  = steps_i.w_step && w_valid_i && ~done_q;
  assign col_step  = row_step && rows_last;
  assign pass_step = col_step && cols_last;
  assign done_set  = pass_step && pass_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      cols_q <= '0;
      pass_q <= '0;
      done_q <= 1'b0;
      zero_q <= '0;
    end else if (clear_i) begin
      rows_q <= '0;
      cols_q <= '0;
      pass_q <= '0;
      done_q <= 1'b0;
      zero_q <= '0;
    end else begin
      if (row_step) begin
        rows_q <= rows_last ? '0 : rows_q + 1'b1;
      end
      if (col_step) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (pass_step) begin
        pass_q <= pass_q + 1'b1;
      end
      if (done_set) begin
        done_q <= 1'b1;
      end
      // After the last weights the array is flushed with zeros, one row per step
      if (done_q && steps_i.w_step && zero_q != zero_cnt_t'(`SCHED_ARRAY_H)) begin
        zero_q <= zero_q + 1'b1;
      end
    end
  end

  always_comb begin
    w_ctrl_o.load     = steps_i.w_step && ~done_q;
    w_ctrl_o.shift    = steps_i.run;
    w_ctrl_o.zero_set = '0;
    for (int unsigned i = 0; i < `SCHED_ARRAY_H; i++) begin
      w_ctrl_o.zero_set[i] = done_q && (zero_q > zero_cnt_t'(i));
    end
  end

  assign w_done_o     = done_q;
  assign w_col_wrap_o = col_step;

endmodule

/* source/x_tile_iter.sv */
// X operand tile iterator

`include "sched_consts.svh"

module x_tile_iter
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  tile_cfg_t  cfg_i,
  input  buf_flags_t flags_i,
  input  logic       x_valid_i,
  input  seq_steps_t steps_i,
  output x_ctrl_t    x_ctrl_o,
  output logic       x_done_o,
  output logic       x_refill_due_o
);

  iter_cnt_t  cols_q;
  iter_cnt_t  w_iters_q;
  iter_cnt_t  rows_q;
  shift_cnt_t shift_q;
  logic       cols_last, w_iters_last, rows_last, shift_last;
  logic       col_step, w_iter_step, row_step;
  logic       done_q, done_set;
  logic       reload_q, reload_set, reload_clr;
  logic       emptied_q;
  logic       refill_q;
  logic       rst_w_index;

  assign cols_last    = cols_q == cfg_i.x_cols_iters - iter_cnt_t'(1);
  assign w_iters_last = w_iters_q == cfg_i.w_cols_iters - iter_cnt_t'(1);
  assign rows_last    = rows_q == cfg_i.x_rows_iters - iter_cnt_t'(1);
  assign shift_last   = shift_q == shift_cnt_t'(`SCHED_ARRAY_H - 1);

  // The empty flag pulses once for every consumed X tile
  assign col_step    = flags_i.x_empty && ~done_q;
  assign w_iter_step = col_step && cols_last;
  assign row_step    = w_iter_step && w_iters_last;
  assign done_set    = row_step && rows_last;

  // A new X tile is requested until the buffer reports full
  assign reload_set  = steps_i.start || col_step || (emptied_q && ~flags_i.x_full);
  assign reload_clr  = flags_i.x_full && ~reload_set;
  assign rst_w_index = steps_i.w_step && flags_i.x_full && (shift_last || flags_i.x_empty);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q    <= '0;
      w_iters_q <= '0;
      rows_q    <= '0;
      done_q    <= 1'b0;
      shift_q   <= '0;
      reload_q  <= 1'b0;
      emptied_q <= 1'b0;
      refill_q  <= 1'b0;
    end else if (clear_i) begin
      cols_q    <= '0;
      w_iters_q <= '0;
      rows_q    <= '0;
      done_q    <= 1'b0;
      shift_q   <= '0;
      reload_q  <= 1'b0;
      emptied_q <= 1'b0;
      refill_q  <= 1'b0;
    end else begin
      if (col_step) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (w_iter_step) begin
        w_iters_q <= w_iters_last ? '0 : w_iters_q + 1'b1;
      end
      if (row_step) begin
        rows_q <= rows_q + 1'b1;
      end
      if (done_set) begin
        done_q <= 1'b1;
      end
      if (steps_i.w_step) begin
        shift_q <= shift_last ? '0 : shift_q + 1'b1;
      end
      if (reload_clr) begin
        reload_q <= 1'b0;
      end else if (reload_set) begin
        reload_q <= 1'b1;
      end
      // Remembers a tile emptied while the buffer still showed full
      if (!flags_i.x_full) begin
        emptied_q <= 1'b0;
      end else if (flags_i.x_empty) begin
        emptied_q <= 1'b1;
      end
      if (flags_i.x_empty) begin
        refill_q <= 1'b1;
      end else if (rst_w_index) begin
        refill_q <= 1'b0;
      end
    end
  end

  always_comb begin
    x_ctrl_o.load        = reload_q && ~reload_clr && x_valid_i;
    x_ctrl_o.h_shift     = steps_i.w_step;
    // Pad setup comes from the sequencer and is merged at the top
    x_ctrl_o.pad_setup   = 1'b0;
    x_ctrl_o.rst_w_index = rst_w_index;
    x_ctrl_o.last_x      = done_set;
  end

  assign x_done_o       = done_q;
  assign x_refill_due_o = refill_q && shift_last && ~done_q;

endmodule

/* source/sched_sequencer.sv */
// Scheduler control sequencer

`include "sched_consts.svh"

module sched_sequencer
  import sched_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  logic         y_needed_i,
  input  buf_flags_t   flags_i,
  input  logic         w_valid_i,
  input  iter_status_t status_i,
  output seq_steps_t   steps_o,
  output logic         pad_setup_o,
  output logic         reg_enable_o,
  output logic         w_loaded_o
);

  sched_state_e state_q, state_d;
  pipe_cnt_t    wait_cnt_q;
  logic         first_load_q;
  logic         computing_q;
  logic         active;
  logic         stall;
  logic         w_check_fail;
  logic         z_check_fail;
  logic         x_check_fail;
  logic         run_end;

  // No more weight rows are expected once the last pass is loaded
  assign w_check_fail = ~w_valid_i && ~status_i.w_done;
  assign z_check_fail = y_needed_i && status_i.z_check_due && ~flags_i.z_loaded;
  // The X refill is checked a cycle early because the buffer needs one cycle to switch
  assign x_check_fail = status_i.x_refill_due && ~flags_i.x_full;

  assign stall = (state_q == LOAD_W && (w_check_fail || z_check_fail)) ||
                 (state_q == WAIT && x_check_fail);

  assign active  = (state_q == LOAD_W) || (state_q == WAIT);
  assign run_end = (state_q == LOAD_W) && status_i.w_done && status_i.z_avail_clr;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PRELOAD;
        end
      end
      PRELOAD: begin
        if (flags_i.x_full && (flags_i.z_loaded || ~y_needed_i)) begin
          state_d = LOAD_W;
        end
      end
      LOAD_W: begin
        if (run_end) begin
          state_d = IDLE;
        end else if (~stall) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (wait_cnt_q == pipe_cnt_t'(`SCHED_PIPE_REGS) && ~stall) begin
          state_d = LOAD_W;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_o <= 1'b0;
    end else if (clear_i) begin
      state_q      <= IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      reg_enable_o <= computing_q && ~stall;
      // One weight row enters the array every PIPE_REGS+1 cycles
      if (!active) begin
        wait_cnt_q <= '0;
      end else if (~stall) begin
        wait_cnt_q <= (wait_cnt_q == pipe_cnt_t'(`SCHED_PIPE_REGS)) ? '0 : wait_cnt_q + 1'b1;
      end
      if (run_end) begin
        first_load_q <= 1'b1;
      end else if (w_loaded_o) begin
        first_load_q <= 1'b0;
      end
      if (run_end) begin
        computing_q <= 1'b0;
      end else if (pad_setup_o) begin
        computing_q <= 1'b1;
      end
    end
  end

  assign pad_setup_o = (state_q == PRELOAD) && (state_d == LOAD_W);
  assign w_loaded_o  = (state_q == LOAD_W) && ~stall;

  always_comb begin
    steps_o.start         = (state_q == IDLE) && start_i;
    steps_o.w_step        = w_loaded_o;
    steps_o.run           = active && ~stall;
    steps_o.in_load_w     = (state_q == LOAD_W);
    steps_o.compute_start = first_load_q && (state_d == LOAD_W) && ~stall;
  end

endmodule

/* source/sched_pkg.sv */
// Scheduler types

`include "sched_consts.svh"

package sched_pkg;

  typedef logic [`SCHED_ITER_W-1:0]                iter_cnt_t;
  typedef logic [$clog2(`SCHED_PIPE_REGS+1)-1:0]   pipe_cnt_t;
  typedef logic [$clog2(`SCHED_DEPTH)-1:0]         depth_cnt_t;
  typedef logic [$clog2(`SCHED_ARRAY_H)-1:0]       shift_cnt_t;
  typedef logic [$clog2(`SCHED_ARRAY_H):0]         zero_cnt_t;
  typedef logic [`SCHED_ARRAY_H-1:0]               row_mask_t;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

  // Loop counts of the tiled product
  typedef struct packed {
    iter_cnt_t x_cols_iters;
    iter_cnt_t x_rows_iters;
    iter_cnt_t w_cols_iters;
    iter_cnt_t w_rows_iters;
    logic      y_needed;
  } tile_cfg_t;

  typedef struct packed {
    logic x_full;
    logic x_empty;
    logic z_loaded;
    logic z_empty;
  } buf_flags_t;

  typedef struct packed {
    logic load;
    logic h_shift;
    logic pad_setup;
    logic rst_w_index;
    logic last_x;
  } x_ctrl_t;

  typedef struct packed {
    logic      load;
    logic      shift;
    row_mask_t zero_set;
  } w_ctrl_t;

  typedef struct packed {
    logic y_push_enable;
    logic fill;
  } z_ctrl_t;

  // Strobes from the sequencer to the iterators
  typedef struct packed {
    logic start;
    logic w_step;
    logic run;
    logic in_load_w;
    logic compute_start;
  } seq_steps_t;

  typedef struct packed {
    logic x_done;
    logic x_refill_due;
    logic w_done;
    logic z_check_due;
    logic z_avail_clr;
  } iter_status_t;

endpackage

/* source/sched_consts.svh */
// Scheduler geometry constants

`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// Rows of processing elements in the array
`define SCHED_ARRAY_H 4

// Columns of processing elements in the array
`define SCHED_ARRAY_W 4

// Pipelined columns handled by every row
`define SCHED_DEPTH 4

// Pipeline registers inside each processing element
`define SCHED_PIPE_REGS 2

// Width of the tile iteration counters
`define SCHED_ITER_W 16

`endif
